/* all.f */
conv_pkg.sv
conv_chan_if.sv
pe.sv
pe_array.sv
psum_adder.sv
conv_layer2.sv
conv_layer2_chk.sv
tb_conv_layer2.sv

/* conv_chan_if.sv */
`timescale 1ns/1ps
interface conv_chan_if;

  logic                 en;        // column strobe, plain level
  conv_pkg::pix_col_t   ifmap_col; // incoming pixel column
  conv_pkg::kern_col_t  filt_0;    // weights for the oldest column
  conv_pkg::kern_col_t  filt_1;    // weights for the middle column
  conv_pkg::kern_col_t  filt_2;    // weights for the new column
  conv_pkg::psum_col_t  psum;      // registered channel psums

  modport array (
    input  en,
    input  ifmap_col,
    input  filt_0,
    input  filt_1,
    input  filt_2,
    output psum
  );

  modport sum (
    input psum
  );

endinterface

/* conv_layer2.sv */
`timescale 1ns/1ps
module conv_layer2 (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  conv_pkg::pix_col_t            ifmap_in_0,  // channel 0 column
  input  conv_pkg::pix_col_t            ifmap_in_1,  // channel 1 column
  input  conv_pkg::pix_col_t            ifmap_in_2,  // channel 2 column
  input  conv_pkg::pix_col_t            ifmap_in_3,  // channel 3 column
  input  logic [conv_pkg::FILT_W-1:0]   filt_in_0,   // oldest-column taps, ch0 on top
  input  logic [conv_pkg::FILT_W-1:0]   filt_in_1,   // middle-column taps
  input  logic [conv_pkg::FILT_W-1:0]   filt_in_2,   // new-column taps
  output conv_pkg::psum_col_t           psum_out_sum,
  output logic                          psum_valid
);

  conv_pkg::pix_col_t ifmap_arr [conv_pkg::N_CH];    // columns indexed by channel

  conv_chan_if ch_if [conv_pkg::N_CH] ();            // one bundle per channel

  assign ifmap_arr[0] = ifmap_in_0;
  assign ifmap_arr[1] = ifmap_in_1;
  assign ifmap_arr[2] = ifmap_in_2;
  assign ifmap_arr[3] = ifmap_in_3;

  for (genvar c = 0; c < conv_pkg::N_CH; c++) begin : g_ch
    localparam int HI = conv_pkg::FILT_W - 1 - conv_pkg::KCOL_W * c; // top bit of ch c

    assign ch_if[c].en        = en;
    assign ch_if[c].ifmap_col = ifmap_arr[c];
    assign ch_if[c].filt_0    = filt_in_0[HI -: conv_pkg::KCOL_W];  // 24-bit slice
    assign ch_if[c].filt_1    = filt_in_1[HI -: conv_pkg::KCOL_W];
    assign ch_if[c].filt_2    = filt_in_2[HI -: conv_pkg::KCOL_W];

    pe_array pe_array_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ch    (ch_if[c])   // drives this channel's psum column
    );
  end

  psum_adder psum_adder_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),           // feeds the warm-up counter
    .ch0          (ch_if[0]),
    .ch1          (ch_if[1]),
    .ch2          (ch_if[2]),
    .ch3          (ch_if[3]),
    .psum_out_sum (psum_out_sum), // sum of four channels
    .psum_valid   (psum_valid)
  );

endmodule

/* conv_layer2_chk.sv */
`timescale 1ns/1ps
module conv_layer2_chk (
  input logic                clk,
  input logic                rst_n,
  input logic                en,
  input conv_pkg::psum_col_t psum_out_sum,
  input logic                psum_valid
);

  // no valid while held in reset
  valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !psum_valid)
    else $error("psum_valid high while rst_n low");

  // valid only follows an enabled edge
  valid_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
    psum_valid |-> $past(en))
    else $error("psum_valid high without en on the previous edge");

  // no enable, no change in the sums
  sum_holds: assert property (@(posedge clk) disable iff (!rst_n)
    !en |=> $stable(psum_out_sum))
    else $error("psum_out_sum changed after a cycle without en");

endmodule

bind conv_layer2 conv_layer2_chk conv_layer2_chk_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .en           (en),
  .psum_out_sum (psum_out_sum),
  .psum_valid   (psum_valid)
);

/* conv_pkg.sv */
package conv_pkg;

  localparam int PIX_W    = 8;               // unsigned pixel bits
  localparam int WGT_W    = 8;               // signed weight bits
  localparam int PSUM_W   = 20;              // psum bits, all sums wrap here
  localparam int K        = 3;               // kernel size
  localparam int ROWS_IN  = 14;              // pixels per column
  localparam int ROWS_OUT = ROWS_IN - K + 1; // output rows, 12
  localparam int N_CH     = 4;               // input channels

  // zero-extended pixel times signed weight
  localparam int PROD_W = PIX_W + 1 + WGT_W;

  localparam int KCOL_W = K * WGT_W;         // one filter column of one channel
  localparam int FILT_W = N_CH * KCOL_W;     // flat filter port, channel 0 on top

  typedef logic [PIX_W-1:0] pixel_t;         // unsigned pixel
  typedef logic signed [WGT_W-1:0] weight_t; // signed weight
  typedef logic signed [PSUM_W-1:0] psum_t;  // two's complement psum

  // element 0 sits in the msbs in all three
  typedef pixel_t [0:ROWS_IN-1] pix_col_t;   // top row first
  typedef weight_t [0:K-1] kern_col_t;       // tap 0 first
  typedef psum_t [0:ROWS_OUT-1] psum_col_t;  // output row 0 first

endpackage

/* pe.sv */
`timescale 1ns/1ps
module pe (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 en,
  input  conv_pkg::pixel_t [0:conv_pkg::K-1]   col_old, // 3 rows of oldest column
  input  conv_pkg::pixel_t [0:conv_pkg::K-1]   col_mid, // 3 rows of middle column
  input  conv_pkg::pixel_t [0:conv_pkg::K-1]   col_new, // 3 rows of incoming column
  input  conv_pkg::kern_col_t                  filt_0,
  input  conv_pkg::kern_col_t                  filt_1,
  input  conv_pkg::kern_col_t                  filt_2,
  output conv_pkg::psum_t                      psum
);

  conv_pkg::pixel_t [0:conv_pkg::K-1] win [conv_pkg::K];  // window, [col][tap]
  conv_pkg::kern_col_t filt [conv_pkg::K];                 // filters by column
  logic signed [conv_pkg::PROD_W-1:0] prod [conv_pkg::K][conv_pkg::K];
  conv_pkg::psum_t col_sum [conv_pkg::K];                  // first tree level
  conv_pkg::psum_t mac;                                     // full 3x3 result

  assign win[0]  = col_old;
  assign win[1]  = col_mid;
  assign win[2]  = col_new;
  assign filt[0] = filt_0;
  assign filt[1] = filt_1;
  assign filt[2] = filt_2;

  always_comb begin
    for (int c = 0; c < conv_pkg::K; c++) begin
      for (int j = 0; j < conv_pkg::K; j++) begin
        prod[c][j] = $signed({1'b0, win[c][j]}) * $signed(filt[c][j]); // pixel made signed
      end
      col_sum[c] = conv_pkg::psum_t'(prod[c][0]) + conv_pkg::psum_t'(prod[c][1])
                 + conv_pkg::psum_t'(prod[c][2]);  // sign-extended column sum
    end
    mac = col_sum[0] + col_sum[1] + col_sum[2];    // wraps at 20 bits
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      psum <= '0;
    end else if (en) begin
      psum <= mac;                                  // one cycle after the en edge
    end
  end

endmodule

/* pe_array.sv */
`timescale 1ns/1ps
module pe_array (
  input logic        clk,
  input logic        rst_n,
  conv_chan_if.array ch
);

  conv_pkg::pix_col_t  col_old;   // column from two enables ago
  conv_pkg::pix_col_t  col_mid;   // column from the last enable
  conv_pkg::psum_col_t psum_col;  // gathered pe registers

  // window shifts only on en, the incoming column is used live
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_old <= '0;
      col_mid <= '0;
    end else if (ch.en) begin
      col_old <= col_mid;         // middle ages out to oldest
      col_mid <= ch.ifmap_col;    // new column becomes middle
    end
  end

  // one pe per output row, row r sees pixel rows r..r+2
  for (genvar r = 0; r < conv_pkg::ROWS_OUT; r++) begin : g_pe
    pe pe_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .en      (ch.en),
      .col_old (col_old[r +: conv_pkg::K]),       // oldest column slice
      .col_mid (col_mid[r +: conv_pkg::K]),       // middle column slice
      .col_new (ch.ifmap_col[r +: conv_pkg::K]),  // incoming column slice
      .filt_0  (ch.filt_0),
      .filt_1  (ch.filt_1),
      .filt_2  (ch.filt_2),
      .psum    (psum_col[r])                      // row r result
    );
  end

  assign ch.psum = psum_col;      // row 0 lands in the msbs

endmodule

/* psum_adder.sv */
`timescale 1ns/1ps
module psum_adder (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,
  conv_chan_if.sum            ch0,
  conv_chan_if.sum            ch1,
  conv_chan_if.sum            ch2,
  conv_chan_if.sum            ch3,
  output conv_pkg::psum_col_t psum_out_sum,
  output logic                psum_valid
);

  logic [1:0] col_cnt;  // enabled columns seen, saturates at K-1

  // cross-channel sum, combinational from the registered channel psums
  always_comb begin
    for (int r = 0; r < conv_pkg::ROWS_OUT; r++) begin
      psum_out_sum[r] = ch0.psum[r] + ch1.psum[r]
                      + ch2.psum[r] + ch3.psum[r];  // two's complement wrap
    end
  end

  // warm-up, window is full from the third enabled column on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_cnt    <= '0;
      psum_valid <= 1'b0;
    end else begin
      if (en && col_cnt != 2'(conv_pkg::K - 1)) begin
        col_cnt <= col_cnt + 2'd1;                  // count until saturated
      end
      psum_valid <= en && (col_cnt == 2'(conv_pkg::K - 1)); // drops after any gap
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# compile and run the conv_layer2 testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f all.f \
  --top-module tb_conv_layer2 -o sim_conv_layer2 > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_conv_layer2 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$SIM_LOG"; then
  exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

/* tb_conv_layer2.sv */
`timescale 1ns/1ps
module tb_conv_layer2;

  localparam int TIMEOUT_CYCLES = 1000;  // about 3x the ~280 cycles used

  logic         clk;
  logic         rst_n;
  logic         en;
  logic [111:0] ifmap [4];               // one pixel column per channel
  logic [95:0]  filt [3];                // oldest middle and new column taps
  conv_pkg::psum_col_t psum_out_sum;
  logic         psum_valid;

  logic [31:0]  lfsr = 32'h5727;         // random source
  logic [447:0] model_old;               // model windows with ch0 in the msbs
  logic [447:0] model_mid;
  logic [239:0] exp_sum;                 // expected sums after the last edge
  logic         exp_valid;
  int           model_cnt;               // enabled columns saturating at 2
  bit           armed = 1'b0;            // compare only after the first edge
  int           errors = 0;
  int           checks = 0;
  int           cycle_cnt;

  conv_layer2 conv_layer2_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .ifmap_in_0   (ifmap[0]),
    .ifmap_in_1   (ifmap[1]),
    .ifmap_in_2   (ifmap[2]),
    .ifmap_in_3   (ifmap[3]),
    .filt_in_0    (filt[0]),
    .filt_in_1    (filt[1]),
    .filt_in_2    (filt[2]),
    .psum_out_sum (psum_out_sum),
    .psum_valid   (psum_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;              // 40 ns period
  end

  // galois step with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      val = {val[30:0], lfsr[0]};        // one step per bit
      lfsr = lfsr_next(lfsr);
    end
    return val;
  endfunction

  // pixel row i of channel c with row 0 at the top of the channel field
  function automatic int pix_at(input logic [447:0] col, input int c, input int i);
    return int'(col[447 - 112*c - 8*i -: 8]);
  endfunction

  function automatic int wgt_at(input logic [95:0] f, input int c, input int j);
    return int'($signed(f[95 - 24*c - 8*j -: 8]));  // signed tap
  endfunction

  function automatic logic [239:0] expected_sums(input logic [447:0] old_c, mid_c, new_c,
                                                 input logic [95:0] f0, f1, f2);
    logic [239:0] res;
    int acc;
    res = '0;
    for (int r = 0; r < 12; r++) begin
      acc = 0;
      for (int c = 0; c < 4; c++) begin
        for (int j = 0; j < 3; j++) begin
          acc += pix_at(old_c, c, r + j) * wgt_at(f0, c, j)
               + pix_at(mid_c, c, r + j) * wgt_at(f1, c, j)
               + pix_at(new_c, c, r + j) * wgt_at(f2, c, j);
        end
      end
      res[239 - 20*r -: 20] = acc[19:0];  // wrap to 20 bits
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [239:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic random_columns();
    for (int c = 0; c < 4; c++) begin
      for (int i = 0; i < 14; i++) begin
        ifmap[c][111 - 8*i -: 8] = 8'(take_bits(8));
      end
    end
  endtask

  task automatic random_weights();
    for (int k = 0; k < 3; k++) begin
      for (int n = 0; n < 12; n++) begin
        filt[k][95 - 8*n -: 8] = 8'(take_bits(8));
      end
    end
  endtask

  // mode 1 all +127 and mode 2 all -128 or else a random pick per tap
  task automatic extreme_inputs(input int mode);
    logic [7:0] w;
    for (int c = 0; c < 4; c++) begin
      ifmap[c] = {14{8'hff}};
    end
    for (int k = 0; k < 3; k++) begin
      for (int n = 0; n < 12; n++) begin
        case (mode)
          1:       w = 8'h7f;
          2:       w = 8'h80;
          default: w = (take_bits(1) != 0) ? 8'h7f : 8'h80;
        endcase
        filt[k][95 - 8*n -: 8] = w;
      end
    end
  endtask

  // reference model that advances on each enabled edge
  always @(posedge clk) begin
    if (!rst_n) begin
      model_old = '0;
      model_mid = '0;
      model_cnt = 0;
      exp_sum   = '0;
      exp_valid = 1'b0;
    end else if (en) begin
      exp_sum   = expected_sums(model_old, model_mid, {ifmap[0], ifmap[1], ifmap[2], ifmap[3]},
                                filt[0], filt[1], filt[2]);
      exp_valid = (model_cnt >= 2);      // third column fills the window
      if (model_cnt < 2) begin
        model_cnt++;
      end
      model_old = model_mid;
      model_mid = {ifmap[0], ifmap[1], ifmap[2], ifmap[3]};
    end else begin
      exp_valid = 1'b0;                  // sums hold and valid drops
    end
    armed = 1'b1;
  end

  // outputs are stable by the falling edge
  always @(negedge clk) begin
    if (armed) begin
      check_value("psum_out_sum", psum_out_sum, exp_sum);
      check_value("psum_valid", 240'(psum_valid), 240'(exp_valid));
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    en    = 1'b1;                        // enabled columns during reset must not land
    random_columns();
    random_weights();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_value("psum_out_sum", psum_out_sum, 240'd0);  // clean after reset
    check_value("psum_valid", 240'(psum_valid), 240'd0);
    for (int k = 1; k <= 3; k++) begin   // warm-up with valid from the third column
      random_weights();
      random_columns();
      en = 1'b1;
      @(negedge clk);
      check_value("psum_valid", 240'(psum_valid), 240'(k == 3));
    end
    random_weights();                    // fixed weights and streaming columns
    repeat (80) begin
      random_columns();
      en = 1'b1;
      @(negedge clk);
    end
    repeat (60) begin                    // new weights every column
      random_weights();
      random_columns();
      @(negedge clk);
    end
    repeat (80) begin                    // random gaps while the inputs keep changing
      en = (take_bits(1) != 0);
      random_weights();
      random_columns();
      @(negedge clk);
    end
    en = 1'b1;
    repeat (4) begin
      extreme_inputs(1);
      @(negedge clk);
    end
    repeat (4) begin
      extreme_inputs(2);
      @(negedge clk);
    end
    repeat (30) begin
      extreme_inputs(0);
      @(negedge clk);
    end
    en = 1'b0;
    repeat (3) @(negedge clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
